// ==== hw/decode_pkg.sv ====
//****************************************
// Shared types for the 6502 decode ROM model.
// Opcodes, T-states, instruction classes and the
// bit positions of the three control vectors.
//****************************************

package decode_pkg;

    // status register
    localparam int P_C = 0;

    localparam int ADDR_W = 12;
    localparam int XFER_W = 21;
    localparam int ALU_W  = 11;

    typedef enum logic [7:0] {
        INX     = 8'hE8,
        INY     = 8'hC8,
        DEX     = 8'hCA,
        DEY     = 8'h88,
        ASL_A   = 8'h0A,
        LSR_A   = 8'h4A,
        ROL_A   = 8'h2A,
        ROR_A   = 8'h6A,
        SEC     = 8'h38,
        CLC     = 8'h18,
        SEI     = 8'h78,
        CLI     = 8'h58,
        TAX     = 8'hAA,
        TAY     = 8'hA8,
        TXA     = 8'h8A,
        TYA     = 8'h98,
        TXS     = 8'h9A,
        TSX     = 8'hBA,
        LDA_IMM = 8'hA9,
        LDX_IMM = 8'hA2,
        LDY_IMM = 8'hA0,
        LDA_ABS = 8'hAD,
        LDX_ABS = 8'hAE,
        LDY_ABS = 8'hAC,
        STA_ABS = 8'h8D,
        PHA     = 8'h48,
        PLA     = 8'h68,
        PLP     = 8'h28,
        NOP     = 8'hEA
    } opcode_e;

    typedef enum logic [1:0] {T0, T1, T2, T3} tstate_e;

    typedef enum logic [2:0] {
        CLS_IMPLIED,
        CLS_FLAG,
        CLS_TRANSFER,
        CLS_IMMEDIATE,
        CLS_ABSOLUTE,
        CLS_PUSH,
        CLS_PULL,
        CLS_NONE
    } op_class_e;

    // address bus and program counter lines
    typedef enum {
        AB_PCL_ADL, AB_PCH_ADH, AB_PCL_PCL, AB_PCH_PCH, AB_I_PC,
        AB_ADL_ABL, AB_ADH_ABH, AB_S_ADL, AB_0_ADH1_7, AB_ADD_ADL,
        AB_DL_ADH, AB_WRITE
    } addr_bit_e;

    // register transfers and flag loads
    typedef enum {
        XF_DL_DB, XF_SB_DB, XF_X_SB, XF_Y_SB, XF_AC_SB, XF_S_SB, XF_AC_DB,
        XF_SB_X, XF_SB_Y, XF_SB_AC, XF_SB_S,
        XF_DBZ_Z, XF_DB0_C, XF_DB1_Z, XF_DB2_I, XF_DB3_D, XF_DB4_B,
        XF_DB6_V, XF_DB7_N,
        XF_IR5_C, XF_IR5_I
    } xfer_bit_e;

    // ALU inputs, operation and result routing
    typedef enum {
        AL_DB_N_ADD, AL_DB_ADD, AL_ADL_ADD, AL_0_ADD, AL_SB_ADD,
        AL_1_ADDC, AL_SUMS, AL_SRS,
        AL_ADD_SB_0_6, AL_ADD_SB_7, AL_ACR_C
    } alu_bit_e;

    // unlisted opcodes fall into CLS_NONE
    function automatic op_class_e classify(input logic [7:0] ir);
        case (ir)
            INX, INY, DEX, DEY,
            ASL_A, LSR_A, ROL_A, ROR_A:        classify = CLS_IMPLIED;
            SEC, CLC, SEI, CLI:                classify = CLS_FLAG;
            TAX, TAY, TXA, TYA, TXS, TSX:      classify = CLS_TRANSFER;
            LDA_IMM, LDX_IMM, LDY_IMM:         classify = CLS_IMMEDIATE;
            LDA_ABS, LDX_ABS, LDY_ABS, STA_ABS: classify = CLS_ABSOLUTE;
            PHA:                               classify = CLS_PUSH;
            PLA, PLP:                          classify = CLS_PULL;
            default:                           classify = CLS_NONE;
        endcase
    endfunction

endpackage

// ==== hw/t_sequencer.sv ====
//****************************************
// T-state sequencer (TCU) of the decode ROM.
// Steps one T-state per clock and wraps to T0
// after the last cycle of the opcode in IR.
//****************************************
`timescale 1ns/1ps

module t_sequencer
    import decode_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst,
    input  logic [7:0] i_ir,
    output tstate_e    o_tcu
);

    tstate_e tcu;
    tstate_e last_t;

    // final T-state per instruction class
    always_comb
    begin
        case (classify(i_ir))
            CLS_PUSH, CLS_PULL: last_t = T2;
            CLS_ABSOLUTE:       last_t = T3;
            default:            last_t = T1;
        endcase
    end

    // T0 never ends an instruction, so the overlapped
    // opcode in T0 always moves on to T1
    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            tcu <= T0;
        end
        else if (tcu == last_t)
        begin
            tcu <= T0;
        end
        else
        begin
            tcu <= tstate_e'(tcu + 2'd1);
        end
    end

    assign o_tcu = tcu;

endmodule

// ==== hw/addr_bus_ctl.sv ====
//****************************************
// Address bus and program counter decode.
// Combinational from opcode and T-state, also
// drives the write strobe.
//****************************************
`timescale 1ns/1ps

module addr_bus_ctl
    import decode_pkg::*;
(
    input  logic [7:0]        i_ir,
    input  tstate_e           i_tcu,
    output logic [ADDR_W-1:0] o_addr_ctl
);

    op_class_e cls;
    logic      fetch;

    assign cls = classify(i_ir);

    always_comb
    begin
        o_addr_ctl = '0;
        fetch = 1'b0;

        case (i_tcu)
            T0:
            begin
                // opcode fetch, PC steps to the next byte
                fetch = 1'b1;
                o_addr_ctl[AB_I_PC] = 1'b1;
            end
            T1:
            begin
                // unknown opcodes leave the buses idle
                fetch = (cls != CLS_NONE) || (i_ir == NOP);
                if (cls == CLS_IMMEDIATE || cls == CLS_ABSOLUTE)
                begin
                    o_addr_ctl[AB_I_PC] = 1'b1;
                end
            end
            T2:
            begin
                if (cls == CLS_PUSH || cls == CLS_PULL)
                begin
                    // stack sits on page 1 while PC is held
                    o_addr_ctl[AB_PCL_PCL]  = 1'b1;
                    o_addr_ctl[AB_PCH_PCH]  = 1'b1;
                    o_addr_ctl[AB_S_ADL]    = 1'b1;
                    o_addr_ctl[AB_ADL_ABL]  = 1'b1;
                    o_addr_ctl[AB_0_ADH1_7] = 1'b1;
                    o_addr_ctl[AB_ADH_ABH]  = 1'b1;
                    o_addr_ctl[AB_WRITE]    = (cls == CLS_PUSH);
                end
                else if (cls == CLS_ABSOLUTE)
                begin
                    // high address byte comes from PC+2
                    fetch = 1'b1;
                end
            end
            T3:
            begin
                if (cls == CLS_ABSOLUTE)
                begin
                    // effective address with low byte from ADD and high byte from DL
                    o_addr_ctl[AB_PCL_PCL] = 1'b1;
                    o_addr_ctl[AB_PCH_PCH] = 1'b1;
                    o_addr_ctl[AB_I_PC]    = 1'b1;
                    o_addr_ctl[AB_ADD_ADL] = 1'b1;
                    o_addr_ctl[AB_ADL_ABL] = 1'b1;
                    o_addr_ctl[AB_DL_ADH]  = 1'b1;
                    o_addr_ctl[AB_ADH_ABH] = 1'b1;
                    o_addr_ctl[AB_WRITE]   = (i_ir == STA_ABS);
                end
            end
            default: ;
        endcase

        // PC onto the address bus and held
        if (fetch)
        begin
            o_addr_ctl[AB_PCL_ADL] = 1'b1;
            o_addr_ctl[AB_ADL_ABL] = 1'b1;
            o_addr_ctl[AB_PCH_ADH] = 1'b1;
            o_addr_ctl[AB_ADH_ABH] = 1'b1;
            o_addr_ctl[AB_PCL_PCL] = 1'b1;
            o_addr_ctl[AB_PCH_PCH] = 1'b1;
        end
    end

endmodule

// ==== hw/reg_xfer_ctl.sv ====
//****************************************
// Register transfer and status flag decode.
// Selects SB sources and destinations and the
// loads of P from DB or from IR bit 5.
//****************************************
`timescale 1ns/1ps

module reg_xfer_ctl
    import decode_pkg::*;
(
    input  logic [7:0]        i_ir,
    input  tstate_e           i_tcu,
    output logic [XFER_W-1:0] o_xfer_ctl
);

    op_class_e cls;

    assign cls = classify(i_ir);

    // register loaded from SB
    function automatic xfer_bit_e sb_dst(input logic [7:0] ir);
        case (ir)
            INX, DEX, TAX, TSX, LDX_IMM, LDX_ABS: sb_dst = XF_SB_X;
            INY, DEY, TAY, LDY_IMM, LDY_ABS:      sb_dst = XF_SB_Y;
            TXS:                                  sb_dst = XF_SB_S;
            default:                              sb_dst = XF_SB_AC;
        endcase
    endfunction

    // register driven onto SB
    function automatic xfer_bit_e sb_src(input logic [7:0] ir);
        case (ir)
            INX, DEX, TXA, TXS: sb_src = XF_X_SB;
            INY, DEY, TYA:      sb_src = XF_Y_SB;
            TSX:                sb_src = XF_S_SB;
            default:            sb_src = XF_AC_SB;
        endcase
    endfunction

    // data latch into a register with Z and N from the value
    function automatic logic [XFER_W-1:0] dl_load(input logic [7:0] ir);
        dl_load = '0;
        dl_load[XF_DL_DB]   = 1'b1;
        dl_load[XF_SB_DB]   = 1'b1;
        dl_load[sb_dst(ir)] = 1'b1;
        dl_load[XF_DBZ_Z]   = 1'b1;
        dl_load[XF_DB7_N]   = 1'b1;
    endfunction

    always_comb
    begin
        o_xfer_ctl = '0;

        case (i_tcu)
            T0:
            begin
                // write-back of the instruction just finished
                if (cls == CLS_IMPLIED)
                begin
                    o_xfer_ctl[sb_dst(i_ir)] = 1'b1;
                    o_xfer_ctl[XF_SB_DB] = 1'b1;
                    o_xfer_ctl[XF_DBZ_Z] = 1'b1;
                    o_xfer_ctl[XF_DB7_N] = 1'b1;
                end
                else if (cls == CLS_PUSH || cls == CLS_PULL)
                begin
                    o_xfer_ctl[XF_SB_S] = 1'b1;
                end
            end
            T1:
            begin
                case (cls)
                    CLS_FLAG:
                    begin
                        if (i_ir == SEC || i_ir == CLC)
                            o_xfer_ctl[XF_IR5_C] = 1'b1;
                        else
                            o_xfer_ctl[XF_IR5_I] = 1'b1;
                    end
                    CLS_IMPLIED:
                    begin
                        o_xfer_ctl[sb_src(i_ir)] = 1'b1;
                        // left shifts add A to itself via DB
                        if (i_ir == ASL_A || i_ir == ROL_A)
                            o_xfer_ctl[XF_SB_DB] = 1'b1;
                    end
                    CLS_TRANSFER:
                    begin
                        o_xfer_ctl[sb_src(i_ir)] = 1'b1;
                        o_xfer_ctl[sb_dst(i_ir)] = 1'b1;
                        // TXS leaves the flags alone
                        if (i_ir != TXS)
                        begin
                            o_xfer_ctl[XF_SB_DB] = 1'b1;
                            o_xfer_ctl[XF_DBZ_Z] = 1'b1;
                            o_xfer_ctl[XF_DB7_N] = 1'b1;
                        end
                    end
                    CLS_IMMEDIATE: o_xfer_ctl = dl_load(i_ir);
                    // low address byte towards the ALU
                    CLS_ABSOLUTE:  o_xfer_ctl[XF_DL_DB] = 1'b1;
                    default: ;
                endcase
            end
            T2:
            begin
                case (i_ir)
                    PHA: o_xfer_ctl[XF_AC_DB] = 1'b1;
                    PLA:
                    begin
                        o_xfer_ctl[XF_DL_DB] = 1'b1;
                        o_xfer_ctl[XF_SB_DB] = 1'b1;
                        o_xfer_ctl[XF_SB_AC] = 1'b1;
                    end
                    PLP:
                    begin
                        // every P bit from the pulled byte
                        o_xfer_ctl[XF_DL_DB] = 1'b1;
                        o_xfer_ctl[XF_DB0_C] = 1'b1;
                        o_xfer_ctl[XF_DB1_Z] = 1'b1;
                        o_xfer_ctl[XF_DB2_I] = 1'b1;
                        o_xfer_ctl[XF_DB3_D] = 1'b1;
                        o_xfer_ctl[XF_DB4_B] = 1'b1;
                        o_xfer_ctl[XF_DB6_V] = 1'b1;
                        o_xfer_ctl[XF_DB7_N] = 1'b1;
                    end
                    default: ;
                endcase
            end
            T3:
            begin
                if (i_ir == STA_ABS)
                    o_xfer_ctl[XF_AC_DB] = 1'b1;
                else if (cls == CLS_ABSOLUTE)
                    o_xfer_ctl = dl_load(i_ir);
            end
            default: ;
        endcase
    end

endmodule

// ==== hw/alu_ctl.sv ====
//****************************************
// ALU control decode.
// Input selection, operation, carry-in and
// result routing back onto SB.
//****************************************
`timescale 1ns/1ps

module alu_ctl
    import decode_pkg::*;
(
    input  logic [7:0]       i_ir,
    input  tstate_e          i_tcu,
    input  logic [7:0]       i_p,
    output logic [ALU_W-1:0] o_alu_ctl
);

    op_class_e cls;

    assign cls = classify(i_ir);

    always_comb
    begin
        o_alu_ctl = '0;

        case (i_tcu)
            T0:
            begin
                // result of the previous instruction onto SB
                if (cls == CLS_IMPLIED || cls == CLS_PUSH || cls == CLS_PULL)
                begin
                    o_alu_ctl[AL_ADD_SB_0_6] = 1'b1;
                    o_alu_ctl[AL_ADD_SB_7]   = 1'b1;
                end
            end
            T1:
            begin
                if (cls == CLS_IMPLIED)
                begin
                    o_alu_ctl[AL_SB_ADD] = 1'b1;
                    case (i_ir)
                        INX, INY:
                        begin
                            // inverted precharge gives 0 and carry-in adds 1
                            o_alu_ctl[AL_DB_N_ADD] = 1'b1;
                            o_alu_ctl[AL_1_ADDC]   = 1'b1;
                            o_alu_ctl[AL_SUMS]     = 1'b1;
                        end
                        DEX, DEY:
                        begin
                            // precharged DB reads as 0xFF
                            o_alu_ctl[AL_DB_ADD] = 1'b1;
                            o_alu_ctl[AL_SUMS]   = 1'b1;
                        end
                        LSR_A, ROR_A:
                        begin
                            o_alu_ctl[AL_SRS]   = 1'b1;
                            o_alu_ctl[AL_ACR_C] = 1'b1;
                        end
                        ASL_A, ROL_A:
                        begin
                            // A + A is a shift left
                            o_alu_ctl[AL_DB_ADD] = 1'b1;
                            o_alu_ctl[AL_SUMS]   = 1'b1;
                            o_alu_ctl[AL_ACR_C]  = 1'b1;
                        end
                        default: ;
                    endcase
                    // rotates shift the old carry in
                    if (i_ir == ROL_A || i_ir == ROR_A)
                        o_alu_ctl[AL_1_ADDC] = i_p[P_C];
                end
                else if (cls == CLS_ABSOLUTE)
                begin
                    // park the low address byte in ADD
                    o_alu_ctl[AL_DB_ADD] = 1'b1;
                    o_alu_ctl[AL_0_ADD]  = 1'b1;
                    o_alu_ctl[AL_SUMS]   = 1'b1;
                end
            end
            T2:
            begin
                case (cls)
                    CLS_PUSH:
                    begin
                        // S - 1
                        o_alu_ctl[AL_ADL_ADD] = 1'b1;
                        o_alu_ctl[AL_SB_ADD]  = 1'b1;
                        o_alu_ctl[AL_SUMS]    = 1'b1;
                    end
                    CLS_PULL:
                    begin
                        // S + 1
                        o_alu_ctl[AL_ADL_ADD] = 1'b1;
                        o_alu_ctl[AL_0_ADD]   = 1'b1;
                        o_alu_ctl[AL_1_ADDC]  = 1'b1;
                        o_alu_ctl[AL_SUMS]    = 1'b1;
                    end
                    CLS_ABSOLUTE:
                    begin
                        // recirculate ADD so the low byte survives
                        o_alu_ctl[AL_ADD_SB_0_6] = 1'b1;
                        o_alu_ctl[AL_ADD_SB_7]   = 1'b1;
                        o_alu_ctl[AL_SB_ADD]     = 1'b1;
                        o_alu_ctl[AL_DB_N_ADD]   = 1'b1;
                        o_alu_ctl[AL_SUMS]       = 1'b1;
                    end
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

endmodule

// ==== hw/decode_rom.sv ====
//****************************************
// Decode ROM top level.
// The sequencer owns the T-state, the three
// decoders turn it into control vectors.
//****************************************
`timescale 1ns/1ps

module decode_rom
    import decode_pkg::*;
(
    input  logic              i_clk,
    input  logic              i_rst,
    input  logic [7:0]        i_ir,
    input  logic [7:0]        i_p,
    output tstate_e           o_tcu,
    output logic [ADDR_W-1:0] o_addr_ctl,
    output logic [XFER_W-1:0] o_xfer_ctl,
    output logic [ALU_W-1:0]  o_alu_ctl
);

    t_sequencer u_seq (
        .i_clk (i_clk),
        .i_rst (i_rst),
        .i_ir  (i_ir),
        .o_tcu (o_tcu)
    );

    // decoders all follow the registered T-state
    addr_bus_ctl u_addr (
        .i_ir       (i_ir),
        .i_tcu      (o_tcu),
        .o_addr_ctl (o_addr_ctl)
    );

    reg_xfer_ctl u_xfer (
        .i_ir       (i_ir),
        .i_tcu      (o_tcu),
        .o_xfer_ctl (o_xfer_ctl)
    );

    alu_ctl u_alu (
        .i_ir      (i_ir),
        .i_tcu     (o_tcu),
        .i_p       (i_p),
        .o_alu_ctl (o_alu_ctl)
    );

endmodule

// ==== test/tb_decode_rom.sv ====
//****************************************
// Testbench for the decode ROM.
// Replays the per-cycle test data file and
// compares T-state and all three control words.
//****************************************
`timescale 1ns/1ps

module tb_decode_rom
    import decode_pkg::*;
();

    localparam int MAX_CYCLES  = 256;
    localparam int RST_CYCLES  = 4;
    localparam int RST_TIMEOUT = 20;

    logic              i_clk;
    logic              i_rst;
    logic [7:0]        i_ir;
    logic [7:0]        i_p;
    tstate_e           o_tcu;
    logic [ADDR_W-1:0] o_addr_ctl;
    logic [XFER_W-1:0] o_xfer_ctl;
    logic [ALU_W-1:0]  o_alu_ctl;

    // one entry per clock cycle
    string             vec_name [MAX_CYCLES];
    logic [7:0]        vec_ir   [MAX_CYCLES];
    logic              vec_c    [MAX_CYCLES];
    logic [1:0]        vec_t    [MAX_CYCLES];
    logic [ADDR_W-1:0] vec_addr [MAX_CYCLES];
    logic [XFER_W-1:0] vec_xfer [MAX_CYCLES];
    logic [ALU_W-1:0]  vec_alu  [MAX_CYCLES];
    int                num_vec;

    int mismatch_count;
    int other_count;

    decode_rom uut (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_ir       (i_ir),
        .i_p        (i_p),
        .o_tcu      (o_tcu),
        .o_addr_ctl (o_addr_ctl),
        .o_xfer_ctl (o_xfer_ctl),
        .o_alu_ctl  (o_alu_ctl)
    );

    initial
    begin
        i_clk = 1'b0;
        forever
        begin
            #5 i_clk = ~i_clk;
        end
    end

    // comment lines start with '#' and the table closes with 'end'
    task automatic load_vectors();
        int          fd;
        int          cnt;
        bit          found_end;
        string       line;
        string       tok;
        logic [31:0] f_ir;
        logic [31:0] f_c;
        logic [31:0] f_t;
        logic [31:0] f_addr;
        logic [31:0] f_xfer;
        logic [31:0] f_alu;

        num_vec = 0;
        found_end = 1'b0;
        fd = $fopen("test/decode_testdata.txt", "r");
        if (fd == 0)
        begin
            $display("cannot open the test data file test/decode_testdata.txt");
            other_count++;
        end
        else
        begin
            while (!found_end && $feof(fd) == 0 && num_vec < MAX_CYCLES)
            begin
                line = "";
                void'($fgets(line, fd));
                cnt = $sscanf(line, "%s", tok);
                if (cnt == 1 && tok == "end")
                begin
                    found_end = 1'b1;
                end
                else if (cnt == 1 && tok.substr(0, 0) != "#")
                begin
                    cnt = $sscanf(line, "%s %h %h %d %h %h %h", tok, f_ir, f_c,
                                  f_t, f_addr, f_xfer, f_alu);
                    if (cnt != 7)
                    begin
                        $display("test data line for %s is incomplete", tok);
                        other_count++;
                    end
                    else
                    begin
                        vec_name[num_vec] = tok;
                        vec_ir[num_vec]   = f_ir[7:0];
                        vec_c[num_vec]    = f_c[0];
                        vec_t[num_vec]    = f_t[1:0];
                        vec_addr[num_vec] = f_addr[ADDR_W-1:0];
                        vec_xfer[num_vec] = f_xfer[XFER_W-1:0];
                        vec_alu[num_vec]  = f_alu[ALU_W-1:0];
                        num_vec++;
                    end
                end
            end
            $fclose(fd);
            if (!found_end)
            begin
                $display("test data ended early, no end marker after %0d cycles", num_vec);
                other_count++;
            end
            else if (num_vec == 0)
            begin
                $display("test data file holds no cycles");
                other_count++;
            end
        end
    endtask

    task automatic apply_inputs(input int k);
        i_ir = vec_ir[k];
        // other P bits opposite the carry so only bit 0 can match
        i_p = {8{~vec_c[k]}};
        i_p[P_C] = vec_c[k];
    endtask

    task automatic check_cycle(input int k);
        assert (o_tcu === vec_t[k])
        else
        begin
            $display("Fail %s cycle %0d tcu: expected %0d, actual %0d",
                     vec_name[k], k, vec_t[k], o_tcu);
            mismatch_count++;
        end
        assert (o_addr_ctl === vec_addr[k])
        else
        begin
            $display("Fail %s cycle %0d addr_ctl: expected %03h, actual %03h",
                     vec_name[k], k, vec_addr[k], o_addr_ctl);
            mismatch_count++;
        end
        assert (o_xfer_ctl === vec_xfer[k])
        else
        begin
            $display("Fail %s cycle %0d xfer_ctl: expected %06h, actual %06h",
                     vec_name[k], k, vec_xfer[k], o_xfer_ctl);
            mismatch_count++;
        end
        assert (o_alu_ctl === vec_alu[k])
        else
        begin
            $display("Fail %s cycle %0d alu_ctl: expected %03h, actual %03h",
                     vec_name[k], k, vec_alu[k], o_alu_ctl);
            mismatch_count++;
        end
    endtask

    task automatic finish_run();
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    endtask

    initial
    begin
        int wait_cnt;

        mismatch_count = 0;
        other_count = 0;
        i_rst = 1'b1;
        i_ir = NOP;
        i_p = '0;
        load_vectors();
        if (num_vec > 0)
            apply_inputs(0);

        repeat (RST_CYCLES) @(posedge i_clk);
        @(negedge i_clk);
        i_rst = 1'b0;

        // sequencer must sit in T0 once reset lets go
        wait_cnt = 0;
        while (o_tcu !== T0 && wait_cnt < RST_TIMEOUT)
        begin
            @(negedge i_clk);
            wait_cnt++;
        end
        if (o_tcu !== T0)
        begin
            $display("timeout waiting for the sequencer to reach T0 after reset");
            other_count++;
        end
        else
        begin
            // check this cycle and then set up the next one
            for (int k = 0; k < num_vec; k++)
            begin
                if (k > 0)
                    @(negedge i_clk);
                check_cycle(k);
                if (k + 1 < num_vec)
                    apply_inputs(k + 1);
            end
        end
        finish_run();
    end

endmodule

// ==== test/decode_testdata.txt ====
# one line per clock cycle, values seen at the falling edge
# name opcode carry tstate addr_ctl xfer_ctl alu_ctl (opcode and words in hex)
reset     EA 0 0 07F 000000 000
nop       EA 0 1 06F 000000 000
nop       EA 0 0 07F 000000 000
tax       AA 0 1 06F 040892 000
tax       AA 0 0 07F 000000 000
tay       A8 1 1 06F 040912 000
tay       A8 1 0 07F 000000 000
txa       8A 0 1 06F 040A06 000
txa       8A 0 0 07F 000000 000
tya       98 0 1 06F 040A0A 000
tya       98 0 0 07F 000000 000
txs       9A 0 1 06F 000404 000
txs       9A 0 0 07F 000000 000
tsx       BA 1 1 06F 0408A2 000
tsx       BA 1 0 07F 000000 000
sec       38 0 1 06F 080000 000
sec       38 0 0 07F 000000 000
clc       18 1 1 06F 080000 000
clc       18 1 0 07F 000000 000
sei       78 0 1 06F 100000 000
sei       78 0 0 07F 000000 000
cli       58 0 1 06F 100000 000
cli       58 0 0 07F 000000 000
lda_imm   A9 0 1 07F 040A03 000
lda_imm   A9 0 0 07F 000000 000
ldx_imm   A2 0 1 07F 040883 000
ldx_imm   A2 0 0 07F 000000 000
ldy_imm   A0 0 1 07F 040903 000
ldy_imm   A0 0 0 07F 000000 000
inx       E8 0 1 06F 000004 071
inx       E8 0 0 07F 040882 300
iny       C8 1 1 06F 000008 071
iny       C8 1 0 07F 040902 300
dex       CA 0 1 06F 000004 052
dex       CA 0 0 07F 040882 300
asl       0A 1 1 06F 000012 452
asl       0A 1 0 07F 040A02 300
lsr       4A 1 1 06F 000010 490
lsr       4A 1 0 07F 040A02 300
rol_c0    2A 0 1 06F 000012 452
rol_c0    2A 0 0 07F 040A02 300
rol_c1    2A 1 1 06F 000012 472
rol_c1    2A 1 0 07F 040A02 300
ror_c0    6A 0 1 06F 000010 490
ror_c0    6A 0 0 07F 040A02 300
ror_c1    6A 1 1 06F 000010 4B0
ror_c1    6A 1 0 07F 040A02 300
pha       48 0 1 06F 000000 000
pha       48 0 2 9EC 000040 054
pha       48 0 0 07F 000400 300
pla       68 0 1 06F 000000 000
pla       68 0 2 1EC 000203 06C
pla       68 0 0 07F 000400 300
plp       28 1 1 06F 000000 000
plp       28 1 2 1EC 07F001 06C
plp       28 1 0 07F 000400 300
lda_abs   AD 0 1 07F 000001 04A
lda_abs   AD 0 2 06F 000000 351
lda_abs   AD 0 3 67C 040A03 000
lda_abs   AD 0 0 07F 000000 000
ldx_abs   AE 0 1 07F 000001 04A
ldx_abs   AE 0 2 06F 000000 351
ldx_abs   AE 0 3 67C 040883 000
ldx_abs   AE 0 0 07F 000000 000
sta_abs   8D 1 1 07F 000001 04A
sta_abs   8D 1 2 06F 000000 351
sta_abs   8D 1 3 E7C 000040 000
sta_abs   8D 1 0 07F 000000 000
unknown   FF 0 1 000 000000 000
unknown   FF 0 0 07F 000000 000
end

// ==== flist.f ====
hw/decode_pkg.sv
hw/t_sequencer.sv
hw/addr_bus_ctl.sv
hw/reg_xfer_ctl.sv
hw/alu_ctl.sv
hw/decode_rom.sv
test/tb_decode_rom.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the decode ROM testbench with Verilator, runs it and
# decides pass or fail from the simulation log.

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log
TOP=tb_decode_rom

verilator --binary --timing --assert -Wno-fatal \
    --top-module "$TOP" -f flist.f --Mdir "$BUILD_DIR" -o "$TOP"
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/$TOP" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TESTS FAILED" "$LOG_FILE"; then
    exit 1
fi
exit 0
